/* src/bp_pkg.sv */
// Branch prediction package
// Table sizes, pc field helpers, counter states and the prediction and update
// records shared by the fetch and decode sides of the predictor
package bp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////
  localparam int PC_W       = 16;                        // Program counter width
  localparam int BP_ENTRIES = 16;                        // Entries per table
  localparam int BP_INDEX_W = 4;                         // Index is pc[4:1]
  localparam int BP_TAG_W   = PC_W - BP_INDEX_W - 1;     // Tag is pc[15:5]

  // 2-bit saturating counter, upper half predicts taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_t;

  // Made at fetch, carried through IF/ID into decode
  typedef struct packed {
    logic              taken;   // Predicted direction
    logic              hit;     // BTB hit
    ctr_t              ctr;     // Counter as read at fetch
    logic [PC_W-1:0]   target;  // BTB target
  } bp_pred_t;

  // Training record from the resolve stage
  typedef struct packed {
    logic                  valid;
    logic                  taken;   // Actual outcome
    logic [BP_INDEX_W-1:0] idx;
    logic [BP_TAG_W-1:0]   tag;
    ctr_t                  ctr;     // Counter seen at fetch
    logic [PC_W-1:0]       target;  // Actual target
  } bp_update_t;

  // Table index, bit 0 is always zero with 2-byte instructions
  function automatic logic [BP_INDEX_W-1:0] pc_idx(input logic [PC_W-1:0] pc);
    return pc[BP_INDEX_W:1];
  endfunction

  function automatic logic [BP_TAG_W-1:0] pc_tag(input logic [PC_W-1:0] pc);
    return pc[PC_W-1:BP_INDEX_W+1];
  endfunction

endpackage

/* src/branch_history_table.sv */
// Branch history table
// 16 two-bit saturating counters indexed by pc[4:1]
// Combinational read at fetch, trained on the edge that ends decode
`timescale 1ns/10ps

module branch_history_table (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [bp_pkg::PC_W-1:0] fetch_pc,
  input  bp_pkg::bp_update_t     upd,
  output bp_pkg::ctr_t           ctr
);
  import bp_pkg::*;

  ctr_t bht_mem [BP_ENTRIES];   // Counter storage
  ctr_t ctr_next;               // Trained value for upd.idx

  //////////////////////////////////////////////////////////////////////
  // Fetch side lookup
  //////////////////////////////////////////////////////////////////////
  assign ctr = bht_mem[pc_idx(fetch_pc)];   // Zero-cycle read

  //////////////////////////////////////////////////////////////////////
  // Saturating counter next state
  //////////////////////////////////////////////////////////////////////
  // Built from the counter read at fetch, not the current entry
  always_comb begin
    ctr_next = upd.ctr;
    case (upd.ctr)
      strong_nt: ctr_next = upd.taken ? weak_nt  : strong_nt;  // Holds at bottom
      weak_nt:   ctr_next = upd.taken ? weak_t   : strong_nt;
      weak_t:    ctr_next = upd.taken ? strong_t : weak_nt;
      strong_t:  ctr_next = upd.taken ? strong_t : weak_t;     // Holds at top
      default:   ctr_next = strong_nt;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////////////
  // Every counter starts strongly not taken
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BP_ENTRIES; i++) begin
        bht_mem[i] <= strong_nt;
      end
    end else if (upd.valid) begin
      bht_mem[upd.idx] <= ctr_next;   // Lookup this cycle still sees old value
    end
  end

endmodule

/* src/branch_target_buffer.sv */
// Branch target buffer
// 16 tagged entries holding the last taken target per index
// Aliased pcs miss on the tag compare, filled only by taken branches
`timescale 1ns/10ps

module branch_target_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [bp_pkg::PC_W-1:0] fetch_pc,
  input  bp_pkg::bp_update_t      upd,
  output logic                    hit,
  output logic [bp_pkg::PC_W-1:0] target
);
  import bp_pkg::*;

  logic [BP_ENTRIES-1:0] valid_q;               // Entry valid bits
  logic [BP_TAG_W-1:0]   tag_mem [BP_ENTRIES];  // pc[15:5] of the branch
  logic [PC_W-1:0]       tgt_mem [BP_ENTRIES];  // Last taken target

  logic [BP_INDEX_W-1:0] rd_idx;
  logic [BP_TAG_W-1:0]   rd_tag;
  logic                  wr_en;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////
  assign rd_idx = pc_idx(fetch_pc);
  assign rd_tag = pc_tag(fetch_pc);

  // Needs a live entry and a matching tag
  assign hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = hit ? tgt_mem[rd_idx] : '0;   // Zero target on a miss

  //////////////////////////////////////////////////////////////////////
  // Fill
  //////////////////////////////////////////////////////////////////////
  // Not-taken resolutions leave the entry alone
  assign wr_en = upd.valid && upd.taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;                    // All entries empty
    end else if (wr_en) begin
      valid_q[upd.idx] <= 1'b1;
    end
  end

  // Tag and target storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[upd.idx] <= upd.tag;      // Replaces any aliased owner
      tgt_mem[upd.idx] <= upd.target;
    end
  end

endmodule

/* src/branch_resolve.sv */
// Branch resolve stage
// IF/ID register for the prediction and pc, with stall hold and flush,
// plus the decode compare that raises mispredict, picks the redirect
// address and forms the table update
`timescale 1ns/10ps

module branch_resolve (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic [bp_pkg::PC_W-1:0] fetch_pc,
  input  logic                    fetch_valid,
  input  logic                    stall,
  input  bp_pkg::bp_pred_t        pred,
  input  logic                    dec_branch,
  input  logic                    dec_taken,
  input  logic [bp_pkg::PC_W-1:0] dec_target,
  output logic                    mispredict,
  output logic [bp_pkg::PC_W-1:0] redirect_pc,
  output bp_pkg::bp_update_t      upd
);
  import bp_pkg::*;

  logic            ifid_valid;   // Slot holds a live instruction
  bp_pred_t        ifid_pred;    // Prediction made at fetch
  logic [PC_W-1:0] ifid_pc;      // pc of the instruction in decode

  logic resolved;                // Branch outcome known this cycle
  logic dir_wrong;
  logic tgt_wrong;

  //////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////
  // Flush beats capture, stall holds the slot
  always_ff @(posedge clk) begin
    if (rst) begin
      ifid_valid <= 1'b0;
    end else if (mispredict) begin
      ifid_valid <= 1'b0;               // Squash the wrong-path slot
    end else if (!stall) begin
      ifid_valid <= fetch_valid;        // Bubble when fetch is idle
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && fetch_valid) begin
      ifid_pred <= pred;
      ifid_pc   <= fetch_pc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode compare
  //////////////////////////////////////////////////////////////////////
  // Decode inputs are ignored under back-pressure
  assign resolved  = ifid_valid && dec_branch && !stall;

  assign dir_wrong = (dec_taken != ifid_pred.taken);
  // Right direction but the BTB gave a stale target
  assign tgt_wrong = dec_taken && ifid_pred.taken && (dec_target != ifid_pred.target);

  assign mispredict = enable && resolved && (dir_wrong || tgt_wrong);

  // Taken goes to the real target, not taken falls through
  assign redirect_pc = dec_taken ? dec_target : ifid_pc + PC_W'(2);

  //////////////////////////////////////////////////////////////////////
  // Table update
  //////////////////////////////////////////////////////////////////////
  // Every resolved branch trains, right or wrong
  assign upd.valid  = enable && resolved;
  assign upd.taken  = dec_taken;
  assign upd.idx    = pc_idx(ifid_pc);
  assign upd.tag    = pc_tag(ifid_pc);
  assign upd.ctr    = ifid_pred.ctr;    // Counter as it was at fetch
  assign upd.target = dec_target;

endmodule

/* src/branch_predictor.sv */
// Branch predictor top
// Joins the history table, target buffer and resolve stage
// and forms the fetch-time prediction
`timescale 1ns/10ps

module branch_predictor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic [bp_pkg::PC_W-1:0] fetch_pc,
  input  logic                    fetch_valid,
  input  logic                    stall,
  input  logic                    dec_branch,
  input  logic                    dec_taken,
  input  logic [bp_pkg::PC_W-1:0] dec_target,
  output logic                    pred_taken,
  output logic [bp_pkg::PC_W-1:0] pred_target,
  output logic                    mispredict,
  output logic [bp_pkg::PC_W-1:0] redirect_pc
);
  import bp_pkg::*;

  ctr_t            bht_ctr;     // Counter at fetch_pc
  logic            btb_hit;
  logic [PC_W-1:0] btb_target;
  bp_pred_t        pred;        // Fetch prediction
  bp_update_t      upd;         // Training from decode

  branch_history_table u_bht (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .upd      (upd),
    .ctr      (bht_ctr)
  );

  branch_target_buffer u_btb (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .upd      (upd),
    .hit      (btb_hit),
    .target   (btb_target)
  );

  //////////////////////////////////////////////////////////////////////
  // Fetch prediction
  //////////////////////////////////////////////////////////////////////
  // Taken only with a BTB hit and a counter in the upper half
  assign pred.taken  = enable && btb_hit && (bht_ctr == weak_t || bht_ctr == strong_t);
  assign pred.hit    = btb_hit;
  assign pred.ctr    = bht_ctr;
  assign pred.target = btb_target;

  assign pred_taken  = pred.taken;
  assign pred_target = pred.target;

  branch_resolve u_resolve (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .stall       (stall),
    .pred        (pred),
    .dec_branch  (dec_branch),
    .dec_taken   (dec_taken),
    .dec_target  (dec_target),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc),
    .upd         (upd)
  );

endmodule

/* bench/bp_ref_model.svh */
// Branch predictor reference model
// Shadow counters, BTB entries and IF/ID slot kept by the testbench,
// with the expected fetch prediction and decode resolution
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

logic [1:0]  m_ctr     [16];   // 0 strong_nt up to 3 strong_t
logic        m_btb_vld [16];
logic [10:0] m_btb_tag [16];   // pc[15:5]
logic [15:0] m_btb_tgt [16];
logic        m_ifid_vld;       // Shadow IF/ID slot
logic        m_ifid_taken;
logic [1:0]  m_ifid_ctr;
logic [15:0] m_ifid_tgt;
logic [15:0] m_ifid_pc;

//////////////////////////////////////////////////////////////////////
// Expected outputs
//////////////////////////////////////////////////////////////////////
function automatic logic model_hit(input logic [15:0] pc);
  return m_btb_vld[pc[4:1]] && (m_btb_tag[pc[4:1]] == pc[15:5]);
endfunction

function automatic logic exp_taken(input logic [15:0] pc);
  return enable && model_hit(pc) && (m_ctr[pc[4:1]] >= 2'd2);   // weak_t or strong_t
endfunction

function automatic logic [15:0] exp_target(input logic [15:0] pc);
  return model_hit(pc) ? m_btb_tgt[pc[4:1]] : 16'h0000;   // Zero on a miss
endfunction

// Outcome known only for a live slot without back-pressure
function automatic logic exp_resolved();
  return m_ifid_vld && dec_branch && !stall;
endfunction

function automatic logic exp_mispredict();
  logic wrong_dir;
  logic wrong_tgt;
  wrong_dir = (dec_taken != m_ifid_taken);
  wrong_tgt = dec_taken && m_ifid_taken && (dec_target != m_ifid_tgt);
  return enable && exp_resolved() && (wrong_dir || wrong_tgt);
endfunction

function automatic logic [15:0] exp_redirect();
  return dec_taken ? dec_target : m_ifid_pc + 16'd2;
endfunction

// One step toward the outcome, held at both ends
function automatic logic [1:0] sat_step(input logic [1:0] c, input logic tk);
  if (tk) begin
    return (c == 2'd3) ? 2'd3 : c + 2'd1;
  end
  return (c == 2'd0) ? 2'd0 : c - 2'd1;
endfunction

//////////////////////////////////////////////////////////////////////
// State update, called once per cycle before the rising edge
//////////////////////////////////////////////////////////////////////
task automatic model_reset();
  for (int i = 0; i < 16; i++) begin
    m_ctr[i]     = 2'd0;
    m_btb_vld[i] = 1'b0;
  end
  m_ifid_vld = 1'b0;
endtask

task automatic model_advance();
  logic        train;
  logic        flush;
  logic        cap_taken;
  logic [1:0]  cap_ctr;
  logic [15:0] cap_tgt;
  train     = enable && exp_resolved();
  flush     = exp_mispredict();
  cap_taken = exp_taken(fetch_pc);          // Lookup sees the old tables
  cap_ctr   = m_ctr[fetch_pc[4:1]];
  cap_tgt   = exp_target(fetch_pc);
  if (train) begin
    m_ctr[m_ifid_pc[4:1]] = sat_step(m_ifid_ctr, dec_taken);   // From the fetched counter
    if (dec_taken) begin
      m_btb_vld[m_ifid_pc[4:1]] = 1'b1;
      m_btb_tag[m_ifid_pc[4:1]] = m_ifid_pc[15:5];
      m_btb_tgt[m_ifid_pc[4:1]] = dec_target;
    end
  end
  if (flush) begin
    m_ifid_vld = 1'b0;
  end else if (!stall) begin
    m_ifid_vld = fetch_valid;
  end
  if (!stall && fetch_valid) begin
    m_ifid_taken = cap_taken;
    m_ifid_ctr   = cap_ctr;
    m_ifid_tgt   = cap_tgt;
    m_ifid_pc    = fetch_pc;
  end
endtask

`endif

/* bench/branch_predictor_tb.sv */
// Branch predictor testbench
// Drives fetch and decode through training, aliasing, mispredicts, stalls,
// flushes and disable, checking every cycle against a reference model
`timescale 1ns/10ps

module branch_predictor_tb;

  logic        clk = 1'b0;
  logic        rst;
  logic        enable;
  logic [15:0] fetch_pc;
  logic        fetch_valid;
  logic        stall;
  logic        dec_branch;
  logic        dec_taken;
  logic [15:0] dec_target;
  logic        pred_taken;
  logic [15:0] pred_target;
  logic        mispredict;
  logic [15:0] redirect_pc;

  integer      seed = 91;
  integer      cycle_count = 0;
  logic        checking = 1'b0;   // Set once the model has been reset
  logic [31:0] rnd;

  `include "bp_ref_model.svh"

  branch_predictor uut (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .stall       (stall),
    .dec_branch  (dec_branch),
    .dec_taken   (dec_taken),
    .dec_target  (dec_target),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc)
  );

  always #50 clk = ~clk;   // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    fail_run($sformatf("MISMATCH %s got=%h expected=%h", name, got, exp));
  endtask

  // Outputs are settled at the falling edge, inputs were driven on the rising one
  task automatic check_outputs();
    logic        e_taken;
    logic [15:0] e_tgt;
    logic        e_mis;
    e_taken = exp_taken(fetch_pc);
    e_tgt   = exp_target(fetch_pc);
    e_mis   = exp_mispredict();
    assert (pred_taken === e_taken)
      else report_mismatch("pred_taken", 16'(pred_taken), 16'(e_taken));
    assert (pred_target === e_tgt)
      else report_mismatch("pred_target", pred_target, e_tgt);
    assert (mispredict === e_mis)
      else report_mismatch("mispredict", 16'(mispredict), 16'(e_mis));
    if (e_mis) begin
      assert (redirect_pc === exp_redirect())
        else report_mismatch("redirect_pc", redirect_pc, exp_redirect());
    end
  endtask

  always @(negedge clk) begin
    if (checking && !rst) check_outputs();
    if (rst) begin
      model_reset();
      checking = 1'b1;
    end else begin
      model_advance();   // Mirrors the coming rising edge
    end
  end

  // Test length is near 200 cycles, so 400 means a hang
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 400) fail_run("Timeout: run exceeded 400 clock cycles");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic drive(input logic [15:0] pc, input logic fv, input logic st,
                       input logic br, input logic tk, input logic [15:0] tgt);
    @(posedge clk);
    fetch_pc    <= pc;
    fetch_valid <= fv;
    stall       <= st;
    dec_branch  <= br;
    dec_taken   <= tk;
    dec_target  <= tgt;
  endtask

  initial begin
    rst         = 1'b1;
    enable      = 1'b1;
    fetch_pc    = 16'h0000;
    fetch_valid = 1'b0;
    stall       = 1'b0;
    dec_branch  = 1'b0;
    dec_taken   = 1'b0;
    dec_target  = 16'h0000;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Cold tables, random pcs all predict not taken
    repeat (12) begin
      rnd = $random(seed);
      drive({rnd[15:1], 1'b0}, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);
    end

    // Train 0x0124 taken, then walk it back down to strong_nt
    repeat (12) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0340);
    repeat (12) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);

    // Same index, other tag must miss
    repeat (8) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0340);
    repeat (3) drive(16'h0a24, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    repeat (2) drive(16'h0a24, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);

    // Wrong target, then wrong direction
    repeat (8) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0340);
    repeat (2) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0560);   // Second one flushed
    drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0000);
    drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    drive(16'h0000, 1'b0, 1'b0, 1'b1, 1'b0, 16'h0000);

    // Stall holds the slot and blocks training
    drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    repeat (4) drive(16'h0a24, 1'b1, 1'b1, 1'b1, 1'b1, 16'h0340);
    drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0560);   // Lookup shows any stalled fill
    drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0340);
    drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);   // Flushed decode

    // Predictor disabled while 0x0124 hits with a taken counter
    drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    enable <= 1'b0;
    repeat (3) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0560);   // Wrong direction, no fill
    repeat (4) drive(16'h0124, 1'b1, 1'b0, 1'b1, 1'b0, 16'h0000);   // Counter keeps strong_t
    drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    enable <= 1'b1;
    repeat (3) drive(16'h0124, 1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);

    // Random mix over a small pc range so tags alias
    repeat (100) begin
      rnd = $random(seed);
      drive({8'h00, rnd[7:1], 1'b0}, rnd[8] | rnd[9], rnd[12:10] == 3'd0,
            rnd[13] | rnd[14], rnd[15], {rnd[31:17], 1'b0});
    end

    drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0000);
    repeat (2) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
src/bp_pkg.sv
src/branch_history_table.sv
src/branch_target_buffer.sv
src/branch_resolve.sv
src/branch_predictor.sv
bench/branch_predictor_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module branch_predictor_tb \
  -o branch_predictor_sim

# The simulator exits nonzero on a failed check, so keep its status out of set -e
./obj_dir/branch_predictor_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
